// ==== upper_mem_pkg.sv ====
package upper_mem_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // word and bus widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int RW          = 16;
    localparam int I_SIZE      = 32;
    localparam int WB_DATA_W   = 16;
    localparam int WB_ADDR_W   = 24;
    localparam int WB_SEL_BITS = 2;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // instruction cache geometry
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int IC_INDEX_W = 4;
    localparam int IC_LINES   = 1 << IC_INDEX_W;
    // word address minus index and half bit
    localparam int IC_TAG_W   = RW - IC_INDEX_W - 1;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // instruction mmu paging
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int PG_VPAGE_W  = 4;
    localparam int PG_OFFSET_W = 12;
    localparam int PG_PPAGE_W  = 12;

    // page table entry 0, entries follow at consecutive addresses
    localparam logic [RW-1:0] SR_IMMU_BASE = 16'h0100;

    // bus master states, shared by data adapter and cache fill
    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_BUS   = 2'd1;
    localparam logic [1:0] ST_RETRY = 2'd2;

    // fetch word address, seen by the cache and by the mmu
    typedef union packed {
        struct packed {
            logic [IC_TAG_W-1:0]   tag;
            logic [IC_INDEX_W-1:0] index;
            logic                  half;
        } cache_view;
        struct packed {
            logic [PG_VPAGE_W-1:0]  vpage;
            logic [PG_OFFSET_W-1:0] offset;
        } page_view;
    } fetch_addr_u;

endpackage

// ==== wb_if.sv ====
`timescale 1ns/1ns

interface wb_if;

    logic                                 cyc;
    logic                                 stb;
    logic                                 we;
    logic [upper_mem_pkg::WB_ADDR_W-1:0]  adr;
    logic [upper_mem_pkg::WB_DATA_W-1:0]  dat_w;
    logic [upper_mem_pkg::WB_DATA_W-1:0]  dat_r;
    logic [upper_mem_pkg::WB_SEL_BITS-1:0] sel;
    logic                                 ack;
    logic                                 err;
    logic                                 rty;

    modport master (
        output cyc, stb, we, adr, dat_w, sel,
        input  dat_r, ack, err, rty
    );

    modport slave (
        input  cyc, stb, we, adr, dat_w, sel,
        output dat_r, ack, err, rty
    );

endinterface

// ==== wishbone_adapter.sv ====
`timescale 1ns/1ns

module wishbone_adapter (
    input  logic                         i_clk,
    input  logic                         i_rst_n,

    input  logic                         i_mem_req,
    input  logic                         i_mem_we,
    input  logic [upper_mem_pkg::RW-1:0] i_mem_addr,
    input  logic [upper_mem_pkg::RW-1:0] i_mem_data,
    output logic [upper_mem_pkg::RW-1:0] o_mem_data,
    output logic                         o_mem_ack,

    wb_if.master                         o_wb
);

    logic [1:0] state;
    logic       cyc_q;
    logic       stb_q;
    logic       we_q;
    logic [upper_mem_pkg::WB_ADDR_W-1:0] adr_q;
    logic [upper_mem_pkg::WB_DATA_W-1:0] dat_q;
    logic       start;

    // ack is still high on the cycle the requester sees it, so skip that cycle
    assign start = (state == upper_mem_pkg::ST_IDLE) && i_mem_req && !o_mem_ack;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state     <= upper_mem_pkg::ST_IDLE;
            cyc_q     <= 1'b0;
            stb_q     <= 1'b0;
            o_mem_ack <= 1'b0;
        end else begin
            o_mem_ack <= 1'b0;
            case (state)
                upper_mem_pkg::ST_IDLE: begin
                    if (start) begin
                        cyc_q <= 1'b1;
                        stb_q <= 1'b1;
                        state <= upper_mem_pkg::ST_BUS;
                    end
                end
                upper_mem_pkg::ST_BUS: begin
                    if (o_wb.ack || o_wb.err) begin
                        cyc_q     <= 1'b0;
                        stb_q     <= 1'b0;
                        o_mem_ack <= 1'b1;
                        state     <= upper_mem_pkg::ST_IDLE;
                    end else if (o_wb.rty) begin
                        // keep the bus, drop the strobe for one cycle
                        stb_q <= 1'b0;
                        state <= upper_mem_pkg::ST_RETRY;
                    end
                end
                upper_mem_pkg::ST_RETRY: begin
                    stb_q <= 1'b1;
                    state <= upper_mem_pkg::ST_BUS;
                end
                default: state <= upper_mem_pkg::ST_IDLE;
            endcase
        end
    end

    // request payload and returned word
    always_ff @(posedge i_clk) begin
        if (start) begin
            we_q  <= i_mem_we;
            adr_q <= {{(upper_mem_pkg::WB_ADDR_W - upper_mem_pkg::RW){1'b0}}, i_mem_addr};
            dat_q <= i_mem_data;
        end
        if (state == upper_mem_pkg::ST_BUS) begin
            if (o_wb.ack) begin
                o_mem_data <= o_wb.dat_r;
            end else if (o_wb.err) begin
                o_mem_data <= '0;
            end
        end
    end

    assign o_wb.cyc   = cyc_q;
    assign o_wb.stb   = stb_q;
    assign o_wb.we    = we_q;
    assign o_wb.adr   = adr_q;
    assign o_wb.dat_w = dat_q;
    assign o_wb.sel   = '1;

    a_stb_in_cyc: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_wb.stb |-> o_wb.cyc)
        else $error("data adapter strobe raised outside a bus cycle");

endmodule

// ==== icache.sv ====
`timescale 1ns/1ns

module icache (
    input  logic                             i_clk,
    input  logic                             i_rst_n,

    input  logic                             i_req,
    input  upper_mem_pkg::fetch_addr_u       i_addr,
    input  logic                             i_flush,
    output logic [upper_mem_pkg::I_SIZE-1:0] o_data,
    output logic                             o_ack,

    wb_if.master                             o_wb
);

    logic [upper_mem_pkg::IC_TAG_W-1:0] tag_mem  [upper_mem_pkg::IC_LINES];
    logic [upper_mem_pkg::I_SIZE-1:0]   data_mem [upper_mem_pkg::IC_LINES];
    logic [upper_mem_pkg::IC_LINES-1:0] valid;

    logic [1:0] state;
    logic       cyc_q;
    logic       stb_q;
    logic       beat;
    logic [upper_mem_pkg::WB_DATA_W-1:0] lo_q;

    logic [upper_mem_pkg::IC_INDEX_W-1:0] idx;
    logic       hit;
    logic       lookup;
    logic       fill_done;

    assign idx = i_addr.cache_view.index;
    assign hit = valid[idx] && (tag_mem[idx] == i_addr.cache_view.tag);

    // one lookup per request, never on the ack cycle itself
    assign lookup    = (state == upper_mem_pkg::ST_IDLE) && i_req && !o_ack;
    assign fill_done = (state == upper_mem_pkg::ST_BUS) && o_wb.ack && beat;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state <= upper_mem_pkg::ST_IDLE;
            cyc_q <= 1'b0;
            stb_q <= 1'b0;
            beat  <= 1'b0;
            o_ack <= 1'b0;
            valid <= '0;
        end else begin
            o_ack <= 1'b0;
            case (state)
                upper_mem_pkg::ST_IDLE: begin
                    if (lookup && hit) begin
                        o_ack <= 1'b1;
                    end else if (lookup) begin
                        cyc_q <= 1'b1;
                        stb_q <= 1'b1;
                        beat  <= 1'b0;
                        state <= upper_mem_pkg::ST_BUS;
                    end
                end
                upper_mem_pkg::ST_BUS: begin
                    if (o_wb.ack && beat) begin
                        cyc_q <= 1'b0;
                        stb_q <= 1'b0;
                        o_ack <= 1'b1;
                        state <= upper_mem_pkg::ST_IDLE;
                    end else if (o_wb.ack) begin
                        beat <= 1'b1;
                    end else if (o_wb.err) begin
                        // abandon the fill, the pending request restarts it
                        cyc_q <= 1'b0;
                        stb_q <= 1'b0;
                        state <= upper_mem_pkg::ST_IDLE;
                    end else if (o_wb.rty) begin
                        stb_q <= 1'b0;
                        state <= upper_mem_pkg::ST_RETRY;
                    end
                end
                upper_mem_pkg::ST_RETRY: begin
                    stb_q <= 1'b1;
                    state <= upper_mem_pkg::ST_BUS;
                end
                default: state <= upper_mem_pkg::ST_IDLE;
            endcase
            if (fill_done) begin
                valid[idx] <= 1'b1;
            end
            // flush wins over a line written on the same edge
            if (i_flush) begin
                valid <= '0;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if ((state == upper_mem_pkg::ST_BUS) && o_wb.ack && !beat) begin
            lo_q <= o_wb.dat_r;
        end
        if (fill_done) begin
            tag_mem[idx]  <= i_addr.cache_view.tag;
            data_mem[idx] <= {o_wb.dat_r, lo_q};
            o_data        <= {o_wb.dat_r, lo_q};
        end else if (lookup && hit) begin
            o_data <= data_mem[idx];
        end
    end

    // even word first, then odd word
    assign o_wb.adr = {{(upper_mem_pkg::WB_ADDR_W - upper_mem_pkg::RW){1'b0}},
                       i_addr.cache_view.tag, idx, beat};
    assign o_wb.cyc   = cyc_q;
    assign o_wb.stb   = stb_q;
    assign o_wb.we    = 1'b0;
    assign o_wb.dat_w = '0;
    assign o_wb.sel   = '1;

    a_ack_with_req: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_ack |-> i_req)
        else $error("fetch ack given with no fetch request pending");

    a_no_write: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_wb.cyc |-> !o_wb.we)
        else $error("instruction cache issued a write cycle");

endmodule

// ==== immu.sv ====
`timescale 1ns/1ns

module immu (
    input  logic                         i_clk,
    input  logic                         i_rst_n,

    input  logic                         i_sr_we,
    input  logic [upper_mem_pkg::RW-1:0] i_sr_addr,
    input  logic [upper_mem_pkg::RW-1:0] i_sr_data,
    input  logic                         i_pag_en,

    wb_if.slave                          i_virt,
    wb_if.master                         o_phys
);

    localparam int ENTRIES = 1 << upper_mem_pkg::PG_VPAGE_W;

    logic [upper_mem_pkg::PG_PPAGE_W-1:0] page_tbl [ENTRIES];

    logic [upper_mem_pkg::RW-1:0]         sr_off;
    logic                                 sr_hit;
    upper_mem_pkg::fetch_addr_u           virt;
    logic [upper_mem_pkg::PG_PPAGE_W-1:0] ppage;

    // entry range check on the offset from the table base
    assign sr_off = i_sr_addr - upper_mem_pkg::SR_IMMU_BASE;
    assign sr_hit = i_sr_we && (sr_off[upper_mem_pkg::RW-1:upper_mem_pkg::PG_VPAGE_W] == '0);

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            for (int i = 0; i < ENTRIES; i++) begin
                page_tbl[i] <= '0;
            end
        end else if (sr_hit) begin
            page_tbl[sr_off[upper_mem_pkg::PG_VPAGE_W-1:0]] <=
                i_sr_data[upper_mem_pkg::PG_PPAGE_W-1:0];
        end
    end

    assign virt  = i_virt.adr[upper_mem_pkg::RW-1:0];
    assign ppage = page_tbl[virt.page_view.vpage];

    assign o_phys.adr = i_pag_en ? {ppage, virt.page_view.offset} :
                        {{(upper_mem_pkg::WB_ADDR_W - upper_mem_pkg::RW){1'b0}}, virt};

    // everything but the address passes straight through
    assign o_phys.cyc   = i_virt.cyc;
    assign o_phys.stb   = i_virt.stb;
    assign o_phys.we    = i_virt.we;
    assign o_phys.dat_w = i_virt.dat_w;
    assign o_phys.sel   = i_virt.sel;
    assign i_virt.dat_r = o_phys.dat_r;
    assign i_virt.ack   = o_phys.ack;
    assign i_virt.err   = o_phys.err;
    assign i_virt.rty   = o_phys.rty;

endmodule

// ==== wishbone_priority_arbiter.sv ====
`timescale 1ns/1ns

module wishbone_priority_arbiter (
    input  logic                                  i_clk,
    input  logic                                  i_rst_n,

    wb_if.slave                                   i_wb0,
    wb_if.slave                                   i_wb1,

    output logic                                  o_wb_cyc,
    output logic                                  o_wb_stb,
    output logic                                  o_wb_we,
    output logic [upper_mem_pkg::WB_ADDR_W-1:0]   o_wb_adr,
    output logic [upper_mem_pkg::WB_DATA_W-1:0]   o_wb_dat,
    output logic [upper_mem_pkg::WB_SEL_BITS-1:0] o_wb_sel,
    input  logic [upper_mem_pkg::WB_DATA_W-1:0]   i_wb_dat,
    input  logic                                  i_wb_ack,
    input  logic                                  i_wb_err,
    input  logic                                  i_wb_rty
);

    logic locked;
    logic owner;
    logic owner_cyc;
    logic sel;

    // 0 is the data master and 1 the fetch master
    assign owner_cyc = owner ? i_wb1.cyc : i_wb0.cyc;
    assign sel       = (locked && owner_cyc) ? owner : (!i_wb0.cyc && i_wb1.cyc);

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            locked <= 1'b0;
            owner  <= 1'b0;
        end else begin
            locked <= o_wb_cyc;
            owner  <= sel;
        end
    end

    assign o_wb_cyc = sel ? i_wb1.cyc   : i_wb0.cyc;
    assign o_wb_stb = sel ? i_wb1.stb   : i_wb0.stb;
    assign o_wb_we  = sel ? i_wb1.we    : i_wb0.we;
    assign o_wb_adr = sel ? i_wb1.adr   : i_wb0.adr;
    assign o_wb_dat = sel ? i_wb1.dat_w : i_wb0.dat_w;
    assign o_wb_sel = sel ? i_wb1.sel   : i_wb0.sel;

    // responses only to the granted master
    assign i_wb0.ack = !sel && i_wb_ack;
    assign i_wb0.err = !sel && i_wb_err;
    assign i_wb0.rty = !sel && i_wb_rty;
    assign i_wb1.ack = sel && i_wb_ack;
    assign i_wb1.err = sel && i_wb_err;
    assign i_wb1.rty = sel && i_wb_rty;

    assign i_wb0.dat_r = i_wb_dat;
    assign i_wb1.dat_r = i_wb_dat;

    a_no_preempt: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_wb_cyc |=> (sel == $past(sel)) || !($past(sel) ? i_wb1.cyc : i_wb0.cyc))
        else $error("bus grant moved away from a master still holding cyc");

endmodule

// ==== upper_mem.sv ====
`timescale 1ns/1ns

module upper_mem (
    input  logic                                  i_clk,
    input  logic                                  i_rst_n,

    input  logic                                  i_data_req,
    input  logic                                  i_data_we,
    input  logic [upper_mem_pkg::RW-1:0]          i_data_addr,
    input  logic [upper_mem_pkg::RW-1:0]          i_data_wdata,
    output logic [upper_mem_pkg::RW-1:0]          o_data_rdata,
    output logic                                  o_data_ack,

    input  logic                                  i_fetch_req,
    input  logic [upper_mem_pkg::RW-1:0]          i_fetch_addr,
    output logic [upper_mem_pkg::I_SIZE-1:0]      o_fetch_instr,
    output logic                                  o_fetch_ack,
    input  logic                                  i_icache_flush,

    input  logic                                  i_sr_we,
    input  logic [upper_mem_pkg::RW-1:0]          i_sr_addr,
    input  logic [upper_mem_pkg::RW-1:0]          i_sr_data,
    input  logic                                  i_pag_en,

    output logic                                  o_wb_cyc,
    output logic                                  o_wb_stb,
    output logic                                  o_wb_we,
    output logic [upper_mem_pkg::WB_ADDR_W-1:0]   o_wb_adr,
    output logic [upper_mem_pkg::WB_DATA_W-1:0]   o_wb_dat,
    output logic [upper_mem_pkg::WB_SEL_BITS-1:0] o_wb_sel,
    input  logic [upper_mem_pkg::WB_DATA_W-1:0]   i_wb_dat,
    input  logic                                  i_wb_ack,
    input  logic                                  i_wb_err,
    input  logic                                  i_wb_rty
);

    wb_if data_bus ();
    wb_if fetch_virt ();
    wb_if fetch_phys ();

    wishbone_adapter data_wbm (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_mem_req  (i_data_req),
        .i_mem_we   (i_data_we),
        .i_mem_addr (i_data_addr),
        .i_mem_data (i_data_wdata),
        .o_mem_data (o_data_rdata),
        .o_mem_ack  (o_data_ack),
        .o_wb       (data_bus)
    );

    icache icache_i (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_req   (i_fetch_req),
        .i_addr  (i_fetch_addr),
        .i_flush (i_icache_flush),
        .o_data  (o_fetch_instr),
        .o_ack   (o_fetch_ack),
        .o_wb    (fetch_virt)
    );

    immu immu_i (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_sr_we   (i_sr_we),
        .i_sr_addr (i_sr_addr),
        .i_sr_data (i_sr_data),
        .i_pag_en  (i_pag_en),
        .i_virt    (fetch_virt),
        .o_phys    (fetch_phys)
    );

    // data master has priority over fetch
    wishbone_priority_arbiter wb_arb (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_wb0    (data_bus),
        .i_wb1    (fetch_phys),
        .o_wb_cyc (o_wb_cyc),
        .o_wb_stb (o_wb_stb),
        .o_wb_we  (o_wb_we),
        .o_wb_adr (o_wb_adr),
        .o_wb_dat (o_wb_dat),
        .o_wb_sel (o_wb_sel),
        .i_wb_dat (i_wb_dat),
        .i_wb_ack (i_wb_ack),
        .i_wb_err (i_wb_err),
        .i_wb_rty (i_wb_rty)
    );

endmodule

// ==== tb_upper_mem.sv ====
`timescale 1ns/1ns

module tb_upper_mem;

    logic        clk;
    logic        rst_n;
    logic        data_req;
    logic        data_we;
    logic [15:0] data_addr;
    logic [15:0] data_wdata;
    logic [15:0] data_rdata;
    logic        data_ack;
    logic        fetch_req;
    logic [15:0] fetch_addr;
    logic [31:0] fetch_instr;
    logic        fetch_ack;
    logic        flush;
    logic        sr_we;
    logic [15:0] sr_addr;
    logic [15:0] sr_data;
    logic        pag_en;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [23:0] wb_adr;
    logic [15:0] wb_dat_o;
    logic [1:0]  wb_sel;
    logic [15:0] wb_dat_i;
    logic        wb_ack;
    logic        wb_rty;

    logic [15:0] mem     [4096];
    logic [15:0] shadow  [4096];
    logic        retried [4096];
    logic [11:0] ptbl    [16];
    logic [31:0] lfsr;
    logic        pending;
    logic [1:0]  delay;
    logic [23:0] last_adr;
    int          bus_cycles;
    logic        data_busy;
    logic        fetch_busy;
    logic        expect_hit;
    logic        arb_pending;
    logic [15:0] exp_rdata;
    logic [31:0] exp_instr;
    logic [23:0] exp_fetch_phys;
    int          fetch_acks;
    int          assert_errs;
    int          timeout_errs;

    upper_mem upper_mem_i (
        .i_clk          (clk),
        .i_rst_n        (rst_n),
        .i_data_req     (data_req),
        .i_data_we      (data_we),
        .i_data_addr    (data_addr),
        .i_data_wdata   (data_wdata),
        .o_data_rdata   (data_rdata),
        .o_data_ack     (data_ack),
        .i_fetch_req    (fetch_req),
        .i_fetch_addr   (fetch_addr),
        .o_fetch_instr  (fetch_instr),
        .o_fetch_ack    (fetch_ack),
        .i_icache_flush (flush),
        .i_sr_we        (sr_we),
        .i_sr_addr      (sr_addr),
        .i_sr_data      (sr_data),
        .i_pag_en       (pag_en),
        .o_wb_cyc       (wb_cyc),
        .o_wb_stb       (wb_stb),
        .o_wb_we        (wb_we),
        .o_wb_adr       (wb_adr),
        .o_wb_dat       (wb_dat_o),
        .o_wb_sel       (wb_sel),
        .i_wb_dat       (wb_dat_i),
        .i_wb_ack       (wb_ack),
        .i_wb_err       (1'b0),
        .i_wb_rty       (wb_rty)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [15:0] fill_word(input logic [11:0] a);
        return {a[3:0], a} ^ 16'h6b2d;
    endfunction

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] draw_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return v;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // wishbone slave model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(posedge clk) begin : slave_model
        logic [31:0] r;
        wb_ack <= 1'b0;
        wb_rty <= 1'b0;
        if (!rst_n) begin
            pending <= 1'b0;
        end else if (wb_cyc && wb_stb && !wb_ack && !wb_rty) begin
            if (!pending) begin
                r = draw_bits(2);
                pending    <= 1'b1;
                delay      <= r[1:0];
                last_adr   <= wb_adr;
                bus_cycles <= bus_cycles + 1;
            end else if (delay != 2'd0) begin
                delay <= delay - 2'd1;
            end else if (last_adr[3:0] == 4'hf && !retried[last_adr[11:0]]) begin
                // first attempt at such an address is turned away
                pending                 <= 1'b0;
                wb_rty                  <= 1'b1;
                retried[last_adr[11:0]] <= 1'b1;
            end else begin
                pending  <= 1'b0;
                wb_ack   <= 1'b1;
                wb_dat_i <= mem[last_adr[11:0]];
                if (wb_we) begin
                    mem[last_adr[11:0]] <= wb_dat_o;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (wb_ack && fetch_busy && wb_adr[23:1] == exp_fetch_phys[23:1]) begin
            fetch_acks <= fetch_acks + 1;
        end
        if (data_ack) begin
            arb_pending <= 1'b0;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    a_sel_full: assert property (@(posedge clk) disable iff (!rst_n)
        wb_stb |-> wb_sel == 2'b11)
        else begin
            assert_errs++;
            $display("MISMATCH o_wb_sel got %h expected 3", $sampled(wb_sel));
        end

    a_bus_adr: assert property (@(posedge clk) disable iff (!rst_n)
        wb_stb |-> (data_busy && wb_adr == {8'h00, data_addr}) ||
                   (fetch_busy && wb_adr[23:1] == exp_fetch_phys[23:1]))
        else begin
            assert_errs++;
            $display("MISMATCH o_wb_adr got %h expected %h or %h", $sampled(wb_adr),
                     {8'h00, $sampled(data_addr)}, $sampled(exp_fetch_phys));
        end

    // only a data store writes, fetch and load cycles read
    a_bus_we: assert property (@(posedge clk) disable iff (!rst_n)
        wb_stb |-> wb_we == (data_busy && data_we && wb_adr == {8'h00, data_addr}))
        else begin
            assert_errs++;
            $display("MISMATCH o_wb_we got %h expected %h", $sampled(wb_we),
                     $sampled(data_busy && data_we && wb_adr == {8'h00, data_addr}));
        end

    // with both requests raised together the data cycle goes first
    a_data_first: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_stb && arb_pending && !data_ack) |-> wb_adr == {8'h00, data_addr})
        else begin
            assert_errs++;
            $display("MISMATCH o_wb_adr got %h expected %h", $sampled(wb_adr),
                     {8'h00, $sampled(data_addr)});
        end

    a_data_rdata: assert property (@(posedge clk) disable iff (!rst_n)
        (data_ack && !data_we) |-> data_rdata == exp_rdata)
        else begin
            assert_errs++;
            $display("MISMATCH o_data_rdata got %h expected %h", $sampled(data_rdata),
                     $sampled(exp_rdata));
        end

    a_fetch_instr: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_ack |-> fetch_instr == exp_instr)
        else begin
            assert_errs++;
            $display("MISMATCH o_fetch_instr got %h expected %h", $sampled(fetch_instr),
                     $sampled(exp_instr));
        end

    a_fetch_hit: assert property (@(posedge clk) disable iff (!rst_n)
        (expect_hit && $rose(fetch_req)) |-> !wb_cyc ##1 (fetch_ack && !wb_cyc))
        else begin
            assert_errs++;
            $display("cache hit was not acked one cycle after the request without a bus cycle");
        end

    a_fetch_miss: assert property (@(posedge clk) disable iff (!rst_n)
        (fetch_ack && !expect_hit) |-> fetch_acks == 2)
        else begin
            assert_errs++;
            $display("fetch miss completed without a two word fill on the bus");
        end

    a_retry: assert property (@(posedge clk) disable iff (!rst_n)
        wb_rty |=> !wb_stb ##1 (wb_stb && wb_adr == $past(wb_adr, 2)))
        else begin
            assert_errs++;
            $display("access turned away by rty was not reissued at the same address");
        end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // requester tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic data_access(input logic we, input logic [15:0] addr,
                               input logic [15:0] wdata);
        int n;
        @(posedge clk);
        data_req   <= 1'b1;
        data_we    <= we;
        data_addr  <= addr;
        data_wdata <= wdata;
        data_busy  <= 1'b1;
        exp_rdata  <= shadow[addr[11:0]];
        if (we) begin
            shadow[addr[11:0]] = wdata;
        end
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!data_ack && n < 200);
        if (!data_ack) begin
            timeout_errs++;
            $display("timeout waiting for the data ack at address %h", addr);
        end
        data_req  <= 1'b0;
        data_busy <= 1'b0;
    endtask

    task automatic fetch_instruction(input logic [15:0] fa, input logic hit);
        int n;
        @(posedge clk);
        fetch_req      <= 1'b1;
        fetch_addr     <= fa;
        expect_hit     <= hit;
        fetch_busy     <= 1'b1;
        fetch_acks     <= 0;
        exp_fetch_phys <= pag_en ? {ptbl[fa[15:12]], fa[11:0]} : {8'h00, fa};
        // odd word in the upper half
        exp_instr      <= {shadow[{fa[11:1], 1'b1}], shadow[{fa[11:1], 1'b0}]};
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!fetch_ack && n < 400);
        if (!fetch_ack) begin
            timeout_errs++;
            $display("timeout waiting for the fetch ack at address %h", fa);
        end
        fetch_req  <= 1'b0;
        fetch_busy <= 1'b0;
    endtask

    task automatic write_page_entry(input int vp, input logic [11:0] pp);
        @(posedge clk);
        sr_we   <= 1'b1;
        sr_addr <= upper_mem_pkg::SR_IMMU_BASE + 16'(vp);
        sr_data <= {4'h9, pp};
        ptbl[vp] = pp;
        @(posedge clk);
        sr_we <= 1'b0;
    endtask

    task automatic pulse_flush();
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
    endtask

    initial begin : stimulus
        logic [31:0] r;
        logic [31:0] v;
        logic [15:0] addr;
        rst_n        = 1'b0;
        data_req     = 1'b0;
        data_we      = 1'b0;
        data_addr    = '0;
        data_wdata   = '0;
        fetch_req    = 1'b0;
        fetch_addr   = '0;
        flush        = 1'b0;
        sr_we        = 1'b0;
        sr_addr      = '0;
        sr_data      = '0;
        pag_en       = 1'b0;
        wb_dat_i     = '0;
        wb_ack       = 1'b0;
        wb_rty       = 1'b0;
        data_busy    = 1'b0;
        fetch_busy   = 1'b0;
        expect_hit   = 1'b0;
        arb_pending  = 1'b0;
        fetch_acks   = 0;
        bus_cycles   = 0;
        assert_errs  = 0;
        timeout_errs = 0;
        lfsr         = 32'hd2719a34;
        for (int a = 0; a < 4096; a++) begin
            mem[a]     = fill_word(12'(a));
            shadow[a]  = fill_word(12'(a));
            retried[a] = 1'b0;
        end
        for (int p = 0; p < 16; p++) begin
            ptbl[p] = '0;
        end
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        // data words live below 0x800 and instructions above
        for (int k = 0; k < 8; k++) begin
            r = draw_bits(16);
            v = draw_bits(16);
            addr = {r[15:12], 1'b0, r[10:1], 1'b0};
            data_access(1'b1, addr, v[15:0]);
            data_access(1'b0, addr, 16'h0000);
        end

        fetch_instruction(16'h0804, 1'b0);
        fetch_instruction(16'h0804, 1'b1);
        fetch_instruction(16'h0805, 1'b1);
        pulse_flush();
        fetch_instruction(16'h0804, 1'b0);

        for (int p = 0; p < 16; p++) begin
            r = draw_bits(12);
            write_page_entry(p, r[11:0]);
        end
        @(posedge clk);
        pag_en <= 1'b1;
        pulse_flush();
        fetch_instruction(16'h0804, 1'b0);
        fetch_instruction(16'h9a30, 1'b0);
        fetch_instruction(16'h9a30, 1'b1);

        @(posedge clk);
        arb_pending <= 1'b1;
        fork
            data_access(1'b0, 16'h0246, 16'h0000);
            fetch_instruction(16'h0c42, 1'b0);
        join

        // low nibble f draws one rty per address
        data_access(1'b0, 16'h056f, 16'h0000);
        data_access(1'b1, 16'h012f, 16'hbeef);
        data_access(1'b0, 16'h012f, 16'h0000);
        fetch_instruction(16'h0a1e, 1'b0);

        repeat (4) @(posedge clk);
        $display("bus cycles %0d, assertion errors %0d, timeouts %0d",
                 bus_cycles, assert_errs, timeout_errs);
        if (assert_errs == 0 && timeout_errs == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== src.f ====
upper_mem_pkg.sv
wb_if.sv
wishbone_adapter.sv
icache.sv
immu.sv
wishbone_priority_arbiter.sv
upper_mem.sv
tb_upper_mem.sv

// ==== Bender.yml ====
package:
  name: upper_mem

sources:
  - upper_mem_pkg.sv
  - wb_if.sv
  - wishbone_adapter.sv
  - icache.sv
  - immu.sv
  - wishbone_priority_arbiter.sv
  - upper_mem.sv
  - target: simulation
    files:
      - tb_upper_mem.sv
